// ==== Makefile ====
TOP = tb_looper_board

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== host_cmd_engine.sv ====
`timescale 1ns/100ps

module host_cmd_engine (
   input  logic                      clk_100mhz_buf,
   input  logic                      rst_n,
   input  logic [7:0]                rx_data,
   input  logic                      rx_valid,
   output logic                      rx_ready,
   output logic [7:0]                tx_data,
   output logic                      tx_valid,
   input  logic                      tx_ready,
   output looper_pkg::mem_req_t      mem_req,
   input  looper_pkg::mem_word_t     mem_rdata,
   output looper_pkg::engine_state_e state
);
   import looper_pkg::*;

   engine_state_e state_q;
   mem_addr_t     addr;
   mem_word_t     data_sr;
   rsp_byte_e     rsp;
   logic          op_write;
   logic [$clog2(word_bytes)-1:0] byte_cnt;
   logic          last_byte;
   logic          rx_take;
   logic          tx_take;

   assign state     = state_q;
   assign last_byte = (int'(byte_cnt) == word_bytes - 1);
   assign rx_take   = rx_valid && rx_ready;
   assign tx_take   = tx_valid && tx_ready;

   ////////////////////////////////////////
   // Handshakes and memory port
   ////////////////////////////////////////

   always_comb begin
      rx_ready = (state_q == IDLE) || (state_q == ADDR_HI) ||
                 (state_q == ADDR_LO) || (state_q == DATA);
      tx_valid = (state_q == SEND_WORD) || (state_q == SEND_BYTE);
      // Word goes out MSB first
      tx_data  = (state_q == SEND_WORD) ? data_sr[63:56] : rsp;
   end

   always_comb begin
      mem_req.en    = (state_q == MEM_WRITE) || (state_q == MEM_READ);
      mem_req.we    = (state_q == MEM_WRITE);
      mem_req.addr  = addr;
      mem_req.wdata = data_sr;
   end

   ////////////////////////////////////////
   // Command FSM
   ////////////////////////////////////////

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= IDLE;
         byte_cnt <= '0;
         op_write <= 1'b0;
         rsp      <= RSP_ACK;
      end else begin
         case (state_q)
            IDLE: begin
               if (rx_take) begin
                  case (host_op_e'(rx_data))
                     OP_WRITE: begin
                        op_write <= 1'b1;
                        state_q  <= ADDR_HI;
                     end
                     OP_READ: begin
                        op_write <= 1'b0;
                        state_q  <= ADDR_HI;
                     end
                     default: begin
                        // Unknown opcode, no address follows
                        rsp     <= RSP_NAK;
                        state_q <= SEND_BYTE;
                     end
                  endcase
               end
            end
            ADDR_HI: begin
               if (rx_take) begin
                  state_q <= ADDR_LO;
               end
            end
            ADDR_LO: begin
               if (rx_take) begin
                  byte_cnt <= '0;
                  state_q  <= op_write ? DATA : MEM_READ;
               end
            end
            DATA: begin
               if (rx_take) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (last_byte) begin
                     state_q <= MEM_WRITE;
                  end
               end
            end
            MEM_WRITE: begin
               rsp     <= RSP_ACK;
               state_q <= SEND_BYTE;
            end
            MEM_READ: state_q <= READ_WAIT;
            READ_WAIT: begin
               // RAM output valid this cycle
               byte_cnt <= '0;
               state_q  <= SEND_WORD;
            end
            SEND_WORD: begin
               if (tx_take) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (last_byte) begin
                     state_q <= IDLE;
                  end
               end
            end
            SEND_BYTE: begin
               if (tx_take) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Address and data shift register, also reused to shift out the read word
   always_ff @(posedge clk_100mhz_buf) begin
      if (state_q == ADDR_HI && rx_take) begin
         // Top two bits of the high byte are ignored
         addr[13:8] <= rx_data[5:0];
      end
      if (state_q == ADDR_LO && rx_take) begin
         addr[7:0] <= rx_data;
      end
      if (state_q == DATA && rx_take) begin
         data_sr <= {data_sr[55:0], rx_data};
      end
      if (state_q == READ_WAIT) begin
         data_sr <= mem_rdata;
      end
      if (state_q == SEND_WORD && tx_take) begin
         data_sr <= {data_sr[55:0], 8'h00};
      end
   end

endmodule

// ==== host_word_ram.sv ====
`timescale 1ns/100ps

module host_word_ram (
   input  logic                  clk_100mhz_buf,
   input  looper_pkg::mem_req_t  mem_req,
   output looper_pkg::mem_word_t mem_rdata
);
   import looper_pkg::*;

   ////////////////////////////////////////
   // 16K x 64 program memory, host port
   ////////////////////////////////////////

   // One word per address value
   mem_word_t mem [2**$bits(mem_addr_t)];

   // Single port, read data registered so it shows up one cycle after enable
   always_ff @(posedge clk_100mhz_buf) begin
      if (mem_req.en) begin
         if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end else begin
            mem_rdata <= mem[mem_req.addr];
         end
      end
   end

endmodule

// ==== looper_board.sv ====
`timescale 1ns/100ps

module looper_board (
   input  logic       clk_100mhz_buf,
   input  logic       rst_n,
   input  logic       rxd,
   input  logic [1:0] br_cfg,
   output logic       txd,
   output logic [3:0] state,
   output logic       GPIO_LED_1
);
   import looper_pkg::*;

   logic [7:0]    rx_data;
   logic          rx_valid;
   logic          rx_ready;
   logic [7:0]    tx_data;
   logic          tx_valid;
   logic          tx_ready;
   mem_req_t      mem_req;
   mem_word_t     mem_rdata;
   engine_state_e eng_state;
   logic [heartbeat_bits-1:0] hb_cnt;

   assign state = eng_state;

   ////////////////////////////////////////
   // Heartbeat LED
   ////////////////////////////////////////

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         hb_cnt     <= '0;
         GPIO_LED_1 <= 1'b0;
      end else begin
         hb_cnt     <= hb_cnt + 1'b1;
         GPIO_LED_1 <= hb_cnt[heartbeat_bits-1];
      end
   end

   ////////////////////////////////////////
   // Host access path
   ////////////////////////////////////////

   uart_rx u_uart_rx (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .rxd            (rxd),
      .br_cfg         (br_cfg),
      .rx_data        (rx_data),
      .rx_valid       (rx_valid),
      .rx_ready       (rx_ready)
   );

   host_cmd_engine u_host_cmd_engine (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .rx_data        (rx_data),
      .rx_valid       (rx_valid),
      .rx_ready       (rx_ready),
      .tx_data        (tx_data),
      .tx_valid       (tx_valid),
      .tx_ready       (tx_ready),
      .mem_req        (mem_req),
      .mem_rdata      (mem_rdata),
      .state          (eng_state)
   );

   // Processor side of the memory is not part of this board build
   host_word_ram u_host_word_ram (
      .clk_100mhz_buf (clk_100mhz_buf),
      .mem_req        (mem_req),
      .mem_rdata      (mem_rdata)
   );

   uart_tx u_uart_tx (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .br_cfg         (br_cfg),
      .tx_data        (tx_data),
      .tx_valid       (tx_valid),
      .tx_ready       (tx_ready),
      .txd            (txd)
   );

endmodule

// ==== looper_pkg.sv ====
package looper_pkg;

   ////////////////////////////////////////
   // Link and board constants
   ////////////////////////////////////////

   // Bytes per memory word on the serial link
   localparam int word_bytes = 8;

   // LED counter width, top bit toggles every 2**21 cycles
   localparam int heartbeat_bits = 22;

   // Clock counts per serial bit
   typedef logic [9:0] baud_cnt_t;

   // Indexed by br_cfg: 115200, 230400, 921600 and a fast sim rate
   localparam baud_cnt_t [3:0] baud_div = {10'd16, 10'd108, 10'd434, 10'd868};

   ////////////////////////////////////////
   // Program memory
   ////////////////////////////////////////

   typedef logic [13:0] mem_addr_t;
   typedef logic [63:0] mem_word_t;

   typedef struct packed {
      logic      en;
      logic      we;
      mem_addr_t addr;
      mem_word_t wdata;
   } mem_req_t;

   ////////////////////////////////////////
   // Host protocol
   ////////////////////////////////////////

   // ASCII W and R
   typedef enum logic [7:0] {
      OP_WRITE = 8'h57,
      OP_READ  = 8'h52
   } host_op_e;

   typedef enum logic [7:0] {
      RSP_ACK = 8'h06,
      RSP_NAK = 8'h15
   } rsp_byte_e;

   typedef enum logic [3:0] {
      IDLE,
      ADDR_HI,
      ADDR_LO,
      DATA,
      MEM_WRITE,
      MEM_READ,
      READ_WAIT,
      SEND_WORD,
      SEND_BYTE
   } engine_state_e;

endpackage

// ==== looper_stimulus.txt ====
# name opcode address(hi,lo as sent) data kind expected
# kinds: ACK or NAK expect one byte, WORD expects the eight-byte read word
wr_basic      57 0123 0123456789abcdef ACK  06
rd_basic      52 0123 0000000000000000 WORD 0123456789abcdef
wr_zero       57 0000 a5a5a5a5a5a5a5a5 ACK  06
wr_top        57 3fff fedcba9876543210 ACK  06
wr_mid        57 2000 0000000100000002 ACK  06
wr_one        57 0001 ffffffffffffffff ACK  06
wr_junk_hi    57 ff00 1122334455667788 ACK  06
rd_top        52 3fff 0000000000000000 WORD fedcba9876543210
rd_one_junk   52 c001 0000000000000000 WORD ffffffffffffffff
rd_zero_junk  52 4000 0000000000000000 WORD a5a5a5a5a5a5a5a5
rd_mid_junk   52 a000 0000000000000000 WORD 0000000100000002
rd_hi_clean   52 3f00 0000000000000000 WORD 1122334455667788
bad_op_a      41 0000 0000000000000000 NAK  15
rd_after_bad  52 0123 0000000000000000 WORD 0123456789abcdef
bad_op_zero   00 0000 0000000000000000 NAK  15
bad_op_ff     ff 0000 0000000000000000 NAK  15
rd_after_ff   52 0000 0000000000000000 WORD a5a5a5a5a5a5a5a5
wr_overwrite  57 0123 deadbeefcafef00d ACK  06
rd_overwrite  52 0123 0000000000000000 WORD deadbeefcafef00d
rd_top_again  52 ffff 0000000000000000 WORD fedcba9876543210

// ==== project.f ====
looper_pkg.sv
uart_rx.sv
uart_tx.sv
host_word_ram.sv
host_cmd_engine.sv
looper_board.sv
tb_clock_gen.sv
tb_looper_board.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk_100mhz_buf,
   output logic rst_n
);

   // 100 MHz board clock, 10 ns period
   initial begin
      clk_100mhz_buf = 1'b0;
      forever #5 clk_100mhz_buf = ~clk_100mhz_buf;
   end

   // Reset low for five rising edges, released just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk_100mhz_buf);
      #1 rst_n = 1'b1;
   end

endmodule

// ==== tb_looper_board.sv ====
`timescale 1ns/100ps

module tb_looper_board;
   import looper_pkg::*;

   // br_cfg 3 gives 16 clocks per serial bit
   localparam int bit_cycles  = 16;
   localparam int rsp_timeout = 4000;
   localparam int led_rise    = 2**21;
   localparam int n_rand      = 32;

   typedef logic [8*24-1:0] name_t;

   logic       clk_100mhz_buf;
   logic       rst_n;
   logic       rxd;
   logic [1:0] br_cfg;
   logic       txd;
   logic [3:0] state;
   logic       GPIO_LED_1;

   int          cycles;
   logic [31:0] rng;
   mem_word_t   rand_words [n_rand];

   tb_clock_gen u_clock_gen (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n)
   );

   looper_board u_dut (
      .clk_100mhz_buf (clk_100mhz_buf),
      .rst_n          (rst_n),
      .rxd            (rxd),
      .br_cfg         (br_cfg),
      .txd            (txd),
      .state          (state),
      .GPIO_LED_1     (GPIO_LED_1)
   );

   // Clock edges since reset release
   always @(posedge clk_100mhz_buf) begin
      if (!rst_n) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
      end
   end

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_bit(input name_t name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %0s expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_state(input name_t name, input engine_state_e exp,
                              input engine_state_e act);
      if (act !== exp) begin
         $display("FAILED %0s expected %0s actual %0s (%0d)", name, exp.name(), act.name(),
                  act);
         abort_run();
      end
   endtask

   task automatic check_rsp(input name_t name, input rsp_byte_e exp, input rsp_byte_e act);
      if (act !== exp) begin
         $display("FAILED %0s expected %02h actual %02h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_word(input name_t name, input mem_word_t exp, input mem_word_t act);
      if (act !== exp) begin
         $display("FAILED %0s expected %016h actual %016h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(input name_t name, input int exp, input int act, input int tol);
      if (act < exp - tol || act > exp + tol) begin
         $display("FAILED %0s expected %0d actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   ////////////////////////////////////////
   // UART driver and monitor
   ////////////////////////////////////////

   // 8N1, LSB first, each bit changes 1 ns after a rising edge
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_100mhz_buf);
         #1 rxd = frame[i];
         repeat (bit_cycles - 1) @(posedge clk_100mhz_buf);
      end
   endtask

   task automatic send_command(input logic [7:0] op, input logic [15:0] addr,
                               input mem_word_t data);
      send_byte(op);
      if (op == OP_WRITE || op == OP_READ) begin
         send_byte(addr[15:8]);
         send_byte(addr[7:0]);
      end
      if (op == OP_WRITE) begin
         for (int i = word_bytes - 1; i >= 0; i--) begin
            send_byte(data[8*i +: 8]);
         end
      end
   endtask

   // Samples on falling edges, away from the DUT's updates
   task automatic recv_byte(input name_t name, output logic [7:0] b);
      int waited;
      waited = 0;
      do begin
         @(negedge clk_100mhz_buf);
         waited++;
         if (waited > rsp_timeout) begin
            $display("%0s: no start bit on txd within %0d cycles", name, rsp_timeout);
            abort_run();
         end
      end while (txd !== 1'b0);
      repeat (bit_cycles / 2) @(negedge clk_100mhz_buf);
      if (txd !== 1'b0) begin
         $display("%0s: start bit on txd ended early", name);
         abort_run();
      end
      for (int i = 0; i < 8; i++) begin
         repeat (bit_cycles) @(negedge clk_100mhz_buf);
         b[i] = txd;
      end
      repeat (bit_cycles) @(negedge clk_100mhz_buf);
      if (txd !== 1'b1) begin
         $display("%0s: stop bit on txd is missing", name);
         abort_run();
      end
   endtask

   // Word arrives most significant byte first
   task automatic recv_word(input name_t name, output mem_word_t w);
      logic [7:0] b;
      for (int i = 0; i < word_bytes; i++) begin
         recv_byte(name, b);
         w = {w[55:0], b};
      end
   endtask

   task automatic expect_response(input name_t name, input logic [63:0] kind,
                                  input mem_word_t expv);
      logic [7:0] b;
      mem_word_t  w;
      if (kind == "WORD") begin
         recv_word(name, w);
         check_word(name, expv, w);
      end else if (kind == "ACK" || kind == "NAK") begin
         recv_byte(name, b);
         check_rsp(name, rsp_byte_e'(expv[7:0]), rsp_byte_e'(b));
      end else begin
         $display("%0s: unknown response kind in the stimulus file", name);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      integer     fd;
      int         n;
      int         lines;
      int         waited;
      string      line;
      name_t      name;
      logic [63:0] kind;
      logic [7:0] op;
      logic [15:0] addr;
      mem_word_t  data;
      mem_word_t  expv;
      logic [7:0] b;
      mem_word_t  w;

      rxd    = 1'b1;
      br_cfg = 2'd3;

      waited = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk_100mhz_buf);
         waited++;
         if (waited > 100) begin
            $display("Reset was never released");
            abort_run();
         end
      end

      // Quiet state after reset
      @(negedge clk_100mhz_buf);
      check_bit("reset_txd", 1'b1, txd);
      check_state("reset_state", IDLE, engine_state_e'(state));
      check_bit("reset_led", 1'b0, GPIO_LED_1);
      for (int i = 0; i < 200; i++) begin
         @(negedge clk_100mhz_buf);
         check_bit("idle_txd", 1'b1, txd);
      end

      // Directed commands from the stimulus file
      fd = $fopen("looper_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open looper_stimulus.txt");
         abort_run();
      end
      lines = 0;
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h %s %h", name, op, addr, data, kind, expv);
            if (n == 6) begin
               send_command(op, addr, data);
               expect_response(name, kind, expv);
               check_state(name, IDLE, engine_state_e'(state));
               lines++;
            end
         end
      end
      $fclose(fd);
      if (lines == 0) begin
         $display("No commands found in looper_stimulus.txt");
         abort_run();
      end

      // Random words over 32 spread addresses, read back in reverse
      rng = 32'heda3;
      for (int i = 0; i < n_rand; i++) begin
         rng = xorshift32(rng);
         rand_words[i][63:32] = rng;
         rng = xorshift32(rng);
         rand_words[i][31:0] = rng;
         send_command(OP_WRITE, 16'(i * 517), rand_words[i]);
         recv_byte("rand_write", b);
         check_rsp("rand_write", RSP_ACK, rsp_byte_e'(b));
      end
      for (int i = n_rand - 1; i >= 0; i--) begin
         send_command(OP_READ, 16'(i * 517), '0);
         recv_word("rand_read", w);
         check_word("rand_read", rand_words[i], w);
      end

      // Heartbeat top bit sets after 2**21 counts
      while (GPIO_LED_1 !== 1'b1) begin
         @(negedge clk_100mhz_buf);
         if (cycles > led_rise + 100) begin
            $display("GPIO_LED_1 did not rise within %0d cycles", led_rise + 100);
            abort_run();
         end
      end
      check_count("led_rise", led_rise, cycles, 2);

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
   input  logic       clk_100mhz_buf,
   input  logic       rst_n,
   input  logic       rxd,
   input  logic [1:0] br_cfg,
   output logic [7:0] rx_data,
   output logic       rx_valid,
   input  logic       rx_ready
);
   import looper_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_BITS,
      RX_DONE
   } rx_state_e;

   rx_state_e rx_state;
   logic [1:0] rxd_sync;
   logic       rxd_prev;
   logic       rxd_s;
   logic       start_edge;
   baud_cnt_t  bit_div;
   baud_cnt_t  half_div;
   baud_cnt_t  cnt;
   logic [3:0] bit_idx;
   logic [7:0] shift_reg;
   logic       stop_ok;

   assign bit_div    = baud_div[br_cfg];
   assign half_div   = bit_div >> 1;
   assign rxd_s      = rxd_sync[1];
   assign start_edge = rxd_prev & ~rxd_s;

   // Two-flop synchronizer, line idles high
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         rxd_sync <= 2'b11;
         rxd_prev <= 1'b1;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         rxd_prev <= rxd_s;
      end
   end

   ////////////////////////////////////////
   // Bit sampling
   ////////////////////////////////////////

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= RX_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
         stop_ok  <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         if (rx_valid && rx_ready) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            RX_IDLE: begin
               if (start_edge) begin
                  // First sample lands mid start bit
                  cnt      <= half_div;
                  bit_idx  <= '0;
                  rx_state <= RX_BITS;
               end
            end
            RX_BITS: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else if (bit_idx == 4'd0 && rxd_s) begin
                  // Glitch, not a real start bit
                  rx_state <= RX_IDLE;
               end else if (bit_idx == 4'd9) begin
                  stop_ok  <= rxd_s;
                  // Finish a little before the stop bit ends
                  cnt      <= half_div - 10'd4;
                  rx_state <= RX_DONE;
               end else begin
                  cnt     <= bit_div - 1'b1;
                  bit_idx <= bit_idx + 1'b1;
               end
            end
            RX_DONE: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else begin
                  // Full holding register drops the new byte
                  if (stop_ok && !rx_valid) begin
                     rx_valid <= 1'b1;
                  end
                  rx_state <= RX_IDLE;
               end
            end
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   // Data bits arrive LSB first, holding register loads at byte end
   always_ff @(posedge clk_100mhz_buf) begin
      if (rx_state == RX_BITS && cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
         shift_reg <= {rxd_s, shift_reg[7:1]};
      end
      if (rx_state == RX_DONE && cnt == '0 && stop_ok && !rx_valid) begin
         rx_data <= shift_reg;
      end
   end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
   input  logic       clk_100mhz_buf,
   input  logic       rst_n,
   input  logic [1:0] br_cfg,
   input  logic [7:0] tx_data,
   input  logic       tx_valid,
   output logic       tx_ready,
   output logic       txd
);
   import looper_pkg::*;

   logic [9:0] frame;
   logic [3:0] bits_left;
   baud_cnt_t  bit_div;
   baud_cnt_t  cnt;
   logic       busy;

   assign bit_div  = baud_div[br_cfg];
   assign tx_ready = !busy;

   // Line follows the low end of the frame, all ones when idle
   assign txd = frame[0];

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         frame     <= '1;
         bits_left <= '0;
         cnt       <= '0;
         busy      <= 1'b0;
      end else if (!busy) begin
         if (tx_valid) begin
            // Stop, data, start
            frame     <= {1'b1, tx_data, 1'b0};
            bits_left <= 4'd9;
            cnt       <= bit_div - 1'b1;
            busy      <= 1'b1;
         end
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end else if (bits_left == '0) begin
         // Stop bit done
         busy <= 1'b0;
      end else begin
         frame     <= {1'b1, frame[9:1]};
         bits_left <= bits_left - 1'b1;
         cnt       <= bit_div - 1'b1;
      end
   end

endmodule
